// ==== systolic_mm.f ====
hw/mm_stream_pkg.sv
hw/mm_regs_pkg.sv
hw/axis_skid_buffer.sv
hw/pe_control.sv
hw/mac_pe.sv
hw/array_cfg_regs.sv
hw/systolic_mm_top.sv
testbench/systolic_mm_sva.sv
testbench/tb_result_checker.sv
testbench/tb_systolic_mm.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_systolic_mm
FILELIST  := systolic_mm.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) && ! grep -q "TB FAILED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_systolic_mm.sv ====
module tb_systolic_mm;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS = 2;
  localparam int COLS = 2;
  localparam int MAX_K = 8;
  // 1 + 3 + 1 + 2 + 10 jobs over the five tests
  localparam int TOTAL_JOBS = 17;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_JOBS + 200;

  logic                                    clk;
  logic                                    reset;
  logic signed [mm_stream_pkg::data_w-1:0] left_data [ROWS];
  logic [ROWS-1:0]                         left_valid;
  logic [ROWS-1:0]                         left_ready;
  logic [ROWS-1:0]                         left_last;
  mm_stream_pkg::ud_word_u                 up_data [COLS];
  logic [COLS-1:0]                         up_valid;
  logic [COLS-1:0]                         up_ready;
  logic [COLS-1:0]                         up_last;
  mm_stream_pkg::ud_word_u                 down_data [COLS];
  logic [COLS-1:0]                         down_valid;
  logic [COLS-1:0]                         down_ready;
  logic [COLS-1:0]                         down_last;
  mm_stream_pkg::user_t                    down_user [COLS];
  logic                                    cfg_wr_en;
  logic [mm_regs_pkg::addr_w-1:0]          cfg_addr;
  logic [mm_regs_pkg::reg_data_w-1:0]      cfg_wdata;
  logic [mm_regs_pkg::reg_data_w-1:0]      cfg_rdata;

  // Job operands with A per row and B per column
  logic signed [15:0] a_mem [TOTAL_JOBS][ROWS][MAX_K];
  logic signed [15:0] b_mem [TOTAL_JOBS][MAX_K][COLS];
  int                 k_len [TOTAL_JOBS];
  // Index of an extra left last on row 0 or -1
  int                 early_last [TOTAL_JOBS];
  bit                 gaps_en;
  bit                 bp_en;
  int                 cur_shift;
  int                 reg_errors;
  int                 cycles;
  int                 tests_run;
  int                 tests_failed;

  systolic_mm_top #(.ROWS(ROWS), .COLS(COLS)) dut0 (
    .clk(clk), .reset(reset),
    .left_data(left_data), .left_valid(left_valid), .left_ready(left_ready),
    .left_last(left_last),
    .up_data(up_data), .up_valid(up_valid), .up_ready(up_ready), .up_last(up_last),
    .down_data(down_data), .down_valid(down_valid), .down_ready(down_ready),
    .down_last(down_last), .down_user(down_user),
    .cfg_wr_en(cfg_wr_en), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata)
  );

  tb_result_checker #(.ROWS(ROWS), .COLS(COLS)) result_chk (
    .clk(clk), .reset(reset),
    .down_data(down_data), .down_valid(down_valid), .down_ready(down_ready),
    .down_last(down_last), .down_user(down_user)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Run limit from the job count
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, results never arrived", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Random back-pressure on the column outputs
  initial begin
    forever begin
      @(negedge clk);
      for (int c = 0; c < COLS; c++) begin
        down_ready[c] = bp_en ? (($urandom % 3) != 0) : 1'b1;
      end
    end
  end

  // Expected C[r][c] over k_lo..k_hi shifted and cut to 16 bits
  function automatic logic [15:0] ref_result(input int j, input int r, input int c,
                                             input int k_lo, input int k_hi,
                                             input int shift);
    logic signed [39:0] acc;
    logic signed [39:0] prod;
    acc = '0;
    for (int k = k_lo; k <= k_hi; k++) begin
      // Operands widen to 40 bits before the multiply
      prod = a_mem[j][r][k] * b_mem[j][k][c];
      acc = acc + prod;
    end
    acc = acc >>> shift;
    return acc[15:0];
  endfunction

  task automatic queue_expected(input int j);
    int lo;
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) begin
        // First row 0 result of a split job is dropped by the row below
        lo = (r == 0 && early_last[j] >= 0) ? early_last[j] + 1 : 0;
        result_chk.expect_result(c, 2'(r), ref_result(j, r, c, lo, k_len[j] - 1, cur_shift),
                                 r == ROWS - 1);
      end
    end
  endtask

  task automatic make_job(input int j, input int k, input bit rnd);
    k_len[j] = k;
    early_last[j] = -1;
    for (int i = 0; i < k; i++) begin
      for (int r = 0; r < ROWS; r++) begin
        a_mem[j][r][i] = rnd ? 16'($urandom) : 16'(300 * (i + 1) - 700 * r);
      end
      for (int c = 0; c < COLS; c++) begin
        b_mem[j][i][c] = rnd ? 16'($urandom) : 16'(-250 * i + 900 * c + 100);
      end
    end
  endtask

  task automatic drive_left(input int r, input int j0, input int n);
    int  i;
    bit  hold;
    hold = 1'b0;
    for (int j = j0; j < j0 + n; j++) begin
      i = 0;
      while (i < k_len[j]) begin
        @(negedge clk);
        if (!hold && gaps_en && ($urandom % 4) == 0) begin
          left_valid[r] = 1'b0;
        end else begin
          left_data[r]  = a_mem[j][r][i];
          left_valid[r] = 1'b1;
          left_last[r]  = (i == k_len[j] - 1) || (r == 0 && i == early_last[j]);
          // Registered ready now decides the next edge
          hold = !left_ready[r];
          if (left_ready[r]) begin
            i++;
          end
        end
      end
    end
    @(negedge clk);
    left_valid[r] = 1'b0;
  endtask

  task automatic drive_up(input int c, input int j0, input int n);
    int                      i;
    bit                      hold;
    mm_stream_pkg::ud_word_u w;
    hold = 1'b0;
    for (int j = j0; j < j0 + n; j++) begin
      i = 0;
      while (i < k_len[j]) begin
        @(negedge clk);
        if (!hold && gaps_en && ($urandom % 4) == 0) begin
          up_valid[c] = 1'b0;
        end else begin
          w.w.reserved = '0;
          w.w.weight   = b_mem[j][i][c];
          up_data[c]   = w;
          up_valid[c]  = 1'b1;
          up_last[c]   = (i == k_len[j] - 1);
          hold = !up_ready[c];
          if (up_ready[c]) begin
            i++;
          end
        end
      end
    end
    @(negedge clk);
    up_valid[c] = 1'b0;
  endtask

  // Streams jobs j0..j0+n-1 back to back and waits for the results
  task automatic run_jobs(input int j0, input int n);
    int budget;
    for (int j = j0; j < j0 + n; j++) begin
      queue_expected(j);
    end
    fork
      drive_left(0, j0, n);
      drive_left(1, j0, n);
      drive_up(0, j0, n);
      drive_up(1, j0, n);
    join
    budget = 40 * n + 100;
    while (result_chk.pending() != 0 && budget > 0) begin
      @(posedge clk);
      budget--;
    end
    result_chk.flush_missing();
  endtask

  task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
    @(negedge clk);
    cfg_wr_en = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_wr_en = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] a, output logic [7:0] d);
    @(negedge clk);
    cfg_addr = a;
    #1;
    d = cfg_rdata;
  endtask

  task automatic expect_reg(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      reg_errors++;
    end
  endtask

  // One line per test from the error delta
  task automatic end_test(input string name, input int errs_before);
    int errs;
    errs = result_chk.errors + reg_errors - errs_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-12s %s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  initial begin
    logic [7:0] rd;
    int         base;
    void'($urandom(81));
    reset = 1'b1;
    cycles = 0;
    reg_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    gaps_en = 1'b0;
    bp_en = 1'b0;
    cur_shift = 8;
    left_valid = '0;
    left_last = '0;
    up_valid = '0;
    up_last = '0;
    down_ready = '1;
    cfg_wr_en = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    for (int r = 0; r < ROWS; r++) begin
      left_data[r] = '0;
    end
    for (int c = 0; c < COLS; c++) begin
      up_data[c] = '0;
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // Fixed 2x2 job with K=4 and the reset shift
    base = result_chk.errors + reg_errors;
    make_job(0, 4, 1'b0);
    run_jobs(0, 1);
    end_test("fixed", base);

    // Gaps on inputs and stalls on outputs
    base = result_chk.errors + reg_errors;
    gaps_en = 1'b1;
    bp_en = 1'b1;
    for (int j = 1; j < 4; j++) begin
      make_job(j, 1 + ($urandom % MAX_K), 1'b1);
    end
    run_jobs(1, 3);
    gaps_en = 1'b0;
    bp_en = 1'b0;
    end_test("backpressure", base);

    // Shift of 0
    base = result_chk.errors + reg_errors;
    write_reg(mm_regs_pkg::reg_shift, 8'd0);
    cur_shift = 0;
    read_reg(mm_regs_pkg::reg_shift, rd);
    expect_reg("cfg_rdata", rd, 8'h00);
    make_job(4, 5, 1'b1);
    run_jobs(4, 1);
    end_test("shift", base);

    // Row 0 left last one word early and then a clean job
    base = result_chk.errors + reg_errors;
    make_job(5, 4, 1'b1);
    early_last[5] = 2;
    run_jobs(5, 1);
    read_reg(mm_regs_pkg::reg_status, rd);
    if (rd[mm_regs_pkg::status_unaligned] !== 1'b1) begin
      $display("[ERROR] cfg_rdata[%0d] got %h expected 1",
               mm_regs_pkg::status_unaligned, rd[mm_regs_pkg::status_unaligned]);
      reg_errors++;
    end
    write_reg(mm_regs_pkg::reg_clear, 8'h01);
    read_reg(mm_regs_pkg::reg_status, rd);
    expect_reg("cfg_rdata", rd, 8'h00);
    make_job(6, 3, 1'b1);
    run_jobs(6, 1);
    end_test("unaligned", base);

    // Ten jobs back to back
    base = result_chk.errors + reg_errors;
    for (int j = 7; j < 17; j++) begin
      make_job(j, 1 + ($urandom % MAX_K), 1'b1);
    end
    run_jobs(7, 10);
    end_test("back2back", base);

    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             tests_run, tests_failed, result_chk.checks, result_chk.errors + reg_errors);
    if (tests_failed == 0 && result_chk.errors + reg_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_result_checker.sv ====
module tb_result_checker #(
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input logic                    clk,
  input logic                    reset,
  input mm_stream_pkg::ud_word_u down_data [COLS],
  input logic [COLS-1:0]         down_valid,
  input logic [COLS-1:0]         down_ready,
  input logic [COLS-1:0]         down_last,
  input mm_stream_pkg::user_t    down_user [COLS]
);

  timeunit 1ns;
  timeprecision 1ps;

  // Expected words per column, row then value
  logic [17:0] exp_word_q [COLS][$];
  bit          exp_last_q [COLS][$];
  logic [17:0] exp_word;
  bit          exp_last;
  int          errors = 0;
  int          checks = 0;

  task automatic expect_result(input int c, input logic [1:0] row,
                               input logic [15:0] value, input bit last);
    exp_word_q[c].push_back({row, value});
    exp_last_q[c].push_back(last);
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int c = 0; c < COLS; c++) begin
      n += exp_word_q[c].size();
    end
    return n;
  endfunction

  // Anything left after the wait never came out
  task automatic flush_missing();
    for (int c = 0; c < COLS; c++) begin
      if (exp_word_q[c].size() != 0) begin
        $display("Column %0d is missing %0d results", c, exp_word_q[c].size());
        errors++;
        exp_word_q[c].delete();
        exp_last_q[c].delete();
      end
    end
  endtask

  // Transfer seen on the edge where valid and ready are both high
  always @(posedge clk) begin
    if (!reset) begin
      for (int c = 0; c < COLS; c++) begin
        if (down_valid[c] && down_ready[c]) begin
          checks++;
          if (exp_word_q[c].size() == 0) begin
            $display("Column %0d delivered a result that was not expected", c);
            errors++;
          end else begin
            exp_word = exp_word_q[c].pop_front();
            exp_last = exp_last_q[c].pop_front();
            if (down_data[c].r.row !== exp_word[17:16]) begin
              $display("[ERROR] down_data[%0d].row got %h expected %h",
                       c, down_data[c].r.row, exp_word[17:16]);
              errors++;
            end
            if (down_data[c].r.value !== exp_word[15:0]) begin
              $display("[ERROR] down_data[%0d].value got %h expected %h",
                       c, down_data[c].r.value, exp_word[15:0]);
              errors++;
            end
            if (down_user[c].is_result !== 1'b1) begin
              $display("[ERROR] down_user[%0d].is_result got %h expected 1",
                       c, down_user[c].is_result);
              errors++;
            end
            if (down_last[c] !== exp_last) begin
              $display("[ERROR] down_last[%0d] got %h expected %h",
                       c, down_last[c], exp_last);
              errors++;
            end
          end
        end
      end
    end
  end

endmodule

// ==== testbench/systolic_mm_sva.sv ====
module systolic_mm_sva #(
  parameter int WIDTH  = 16,
  parameter int USER_W = 1
) (
  input logic              clk,
  input logic              reset,
  input logic              out_valid,
  input logic              out_ready,
  input logic [WIDTH-1:0]  out_data,
  input logic              out_last,
  input logic [USER_W-1:0] out_user
);

  timeunit 1ns;
  timeprecision 1ps;

  // Stalled word holds until taken
  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
      && $stable(out_user))
    else $error("skid buffer output changed while stalled");

  // Buffer comes out of reset empty
  empty_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("skid buffer output valid after reset");

endmodule

bind axis_skid_buffer systolic_mm_sva #(.WIDTH(WIDTH), .USER_W(USER_W)) sva0 (
  .clk(clk), .reset(reset), .out_valid(out_valid), .out_ready(out_ready),
  .out_data(out_data), .out_last(out_last), .out_user(out_user)
);

// ==== hw/systolic_mm_top.sv ====
module systolic_mm_top #(
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                                    clk,
  input  logic                                    reset,
  // Operand A, one stream per row
  input  logic signed [mm_stream_pkg::data_w-1:0] left_data [ROWS],
  input  logic [ROWS-1:0]                         left_valid,
  output logic [ROWS-1:0]                         left_ready,
  input  logic [ROWS-1:0]                         left_last,
  // Operand B, one stream per column
  input  mm_stream_pkg::ud_word_u                 up_data [COLS],
  input  logic [COLS-1:0]                         up_valid,
  output logic [COLS-1:0]                         up_ready,
  input  logic [COLS-1:0]                         up_last,
  // Results, row 0 first
  output mm_stream_pkg::ud_word_u                 down_data [COLS],
  output logic [COLS-1:0]                         down_valid,
  input  logic [COLS-1:0]                         down_ready,
  output logic [COLS-1:0]                         down_last,
  output mm_stream_pkg::user_t                    down_user [COLS],
  // Configuration port
  input  logic                                    cfg_wr_en,
  input  logic [mm_regs_pkg::addr_w-1:0]          cfg_addr,
  input  logic [mm_regs_pkg::reg_data_w-1:0]      cfg_wdata,
  output logic [mm_regs_pkg::reg_data_w-1:0]      cfg_rdata
);

  // Horizontal links, column COLS is the dropped outflow
  logic signed [mm_stream_pkg::data_w-1:0] h_data [ROWS][COLS+1];
  logic [COLS:0]                           h_valid [ROWS];
  logic [COLS:0]                           h_ready [ROWS];
  logic [COLS:0]                           h_last [ROWS];
  // Vertical links, row ROWS is the column output
  mm_stream_pkg::ud_word_u                 v_data [ROWS+1][COLS];
  logic [COLS-1:0]                         v_valid [ROWS+1];
  logic [COLS-1:0]                         v_ready [ROWS+1];
  logic [COLS-1:0]                         v_last [ROWS+1];
  mm_stream_pkg::user_t                    v_user [ROWS+1][COLS];
  logic [mm_regs_pkg::shift_w-1:0]         result_shift;
  logic [ROWS*COLS-1:0]                    pe_err_unaligned;
  logic [ROWS*COLS-1:0]                    pe_err_unexpected;

  genvar r, c;

  generate
    for (r = 0; r < ROWS; r++) begin : g_left_edge
      assign h_data[r][0]     = left_data[r];
      assign h_valid[r][0]    = left_valid[r];
      assign h_last[r][0]     = left_last[r];
      assign left_ready[r]    = h_ready[r][0];
      // Right column never forwards, sink always ready
      assign h_ready[r][COLS] = 1'b1;
    end

    for (c = 0; c < COLS; c++) begin : g_col_edge
      assign v_data[0][c]     = up_data[c];
      assign v_valid[0][c]    = up_valid[c];
      assign v_last[0][c]     = up_last[c];
      // Edge words are always weights
      assign v_user[0][c]     = '0;
      assign up_ready[c]      = v_ready[0][c];
      assign down_data[c]     = v_data[ROWS][c];
      assign down_valid[c]    = v_valid[ROWS][c];
      assign down_last[c]     = v_last[ROWS][c];
      assign down_user[c]     = v_user[ROWS][c];
      assign v_ready[ROWS][c] = down_ready[c];
    end

    for (r = 0; r < ROWS; r++) begin : g_row
      for (c = 0; c < COLS; c++) begin : g_col
        mac_pe #(.ROWS(ROWS), .COLS(COLS), .ROW(r), .COL(c)) pe (
          .clk(clk), .reset(reset),
          .left_data(h_data[r][c]), .left_valid(h_valid[r][c]),
          .left_ready(h_ready[r][c]), .left_last(h_last[r][c]),
          .up_data(v_data[r][c]), .up_valid(v_valid[r][c]), .up_ready(v_ready[r][c]),
          .up_last(v_last[r][c]), .up_user(v_user[r][c]),
          .right_data(h_data[r][c+1]), .right_valid(h_valid[r][c+1]),
          .right_ready(h_ready[r][c+1]), .right_last(h_last[r][c+1]),
          .down_data(v_data[r+1][c]), .down_valid(v_valid[r+1][c]),
          .down_ready(v_ready[r+1][c]), .down_last(v_last[r+1][c]),
          .down_user(v_user[r+1][c]),
          .result_shift(result_shift),
          .err_unaligned(pe_err_unaligned[r*COLS+c]),
          .err_unexpected(pe_err_unexpected[r*COLS+c])
        );
      end
    end
  endgenerate

  array_cfg_regs regs (
    .clk(clk), .reset(reset),
    .wr_en(cfg_wr_en), .addr(cfg_addr), .wdata(cfg_wdata), .rdata(cfg_rdata),
    .result_shift(result_shift),
    .err_unaligned(|pe_err_unaligned),
    .err_unexpected(|pe_err_unexpected)
  );

endmodule

// ==== hw/array_cfg_regs.sv ====
module array_cfg_regs (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               wr_en,
  input  logic [mm_regs_pkg::addr_w-1:0]     addr,
  input  logic [mm_regs_pkg::reg_data_w-1:0] wdata,
  output logic [mm_regs_pkg::reg_data_w-1:0] rdata,
  output logic [mm_regs_pkg::shift_w-1:0]    result_shift,
  // OR of the pulses from all PEs
  input  logic                               err_unaligned,
  input  logic                               err_unexpected
);

  logic [mm_regs_pkg::status_w-1:0] status;
  logic [mm_regs_pkg::status_w-1:0] status_set;
  logic                             clear_hit;

  assign clear_hit = wr_en && (addr == mm_regs_pkg::reg_clear);

  always_comb begin
    status_set = '0;
    status_set[mm_regs_pkg::status_unaligned]  = err_unaligned;
    status_set[mm_regs_pkg::status_unexpected] = err_unexpected;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_shift <= mm_regs_pkg::shift_reset;
      status       <= '0;
    end else begin
      // New shift seen by the PEs from the next cycle
      if (wr_en && addr == mm_regs_pkg::reg_shift) begin
        result_shift <= wdata[mm_regs_pkg::shift_w-1:0];
      end
      // A pulse in the clear cycle still sets its flag
      status <= (clear_hit ? '0 : status) | status_set;
    end
  end

  // Combinational read port
  always_comb begin
    rdata = '0;
    case (addr)
      mm_regs_pkg::reg_shift:  rdata[mm_regs_pkg::shift_w-1:0] = result_shift;
      mm_regs_pkg::reg_status: rdata[mm_regs_pkg::status_w-1:0] = status;
      default: rdata = '0;
    endcase
  end

endmodule

// ==== hw/mac_pe.sv ====
module mac_pe #(
  parameter int ROWS = 2,
  parameter int COLS = 2,
  parameter int ROW  = 0,
  parameter int COL  = 0
) (
  input  logic                                    clk,
  input  logic                                    reset,
  // Activations from the left
  input  logic signed [mm_stream_pkg::data_w-1:0] left_data,
  input  logic                                    left_valid,
  output logic                                    left_ready,
  input  logic                                    left_last,
  // Weights, or results of the rows above
  input  mm_stream_pkg::ud_word_u                 up_data,
  input  logic                                    up_valid,
  output logic                                    up_ready,
  input  logic                                    up_last,
  input  mm_stream_pkg::user_t                    up_user,
  output logic signed [mm_stream_pkg::data_w-1:0] right_data,
  output logic                                    right_valid,
  input  logic                                    right_ready,
  output logic                                    right_last,
  output mm_stream_pkg::ud_word_u                 down_data,
  output logic                                    down_valid,
  input  logic                                    down_ready,
  output logic                                    down_last,
  output mm_stream_pkg::user_t                    down_user,
  input  logic [mm_regs_pkg::shift_w-1:0]         result_shift,
  output logic                                    err_unaligned,
  output logic                                    err_unexpected
);

  localparam int data_w = mm_stream_pkg::data_w;
  localparam int acc_w  = mm_stream_pkg::acc_w;
  localparam int rw     = mm_stream_pkg::row_idx_w;
  localparam bit fwd_right = (COL != COLS - 1);
  localparam bit fwd_down  = (ROW != ROWS - 1);
  localparam logic [rw-1:0] row_id = ROW[rw-1:0];

  // Buffered inputs
  logic signed [data_w-1:0] l_data;
  logic                     l_valid;
  logic                     l_last;
  mm_stream_pkg::ud_word_u  u_data;
  logic                     u_valid;
  logic                     u_ready;
  logic                     u_last;
  mm_stream_pkg::user_t     u_user;
  // Output buffer write side
  logic                     r_ready;
  mm_stream_pkg::ud_word_u  d_data;
  logic                     d_valid;
  logic                     d_ready;
  logic                     d_last;
  mm_stream_pkg::user_t     d_user;
  // Control
  logic                     fire;
  logic                     acc_clear;
  logic                     take_up_result;
  logic                     export_own;
  logic                     own_last;
  // Datapath
  logic signed [2*data_w-1:0] product;
  logic signed [acc_w-1:0]    acc;
  logic signed [acc_w-1:0]    acc_base;
  logic signed [acc_w-1:0]    acc_shifted;
  mm_stream_pkg::ud_word_u    own_word;
  mm_stream_pkg::user_t       own_user;

  axis_skid_buffer #(.WIDTH(data_w), .USER_W(1)) left_buf (
    .clk(clk), .reset(reset),
    .in_data(left_data), .in_valid(left_valid), .in_ready(left_ready),
    .in_last(left_last), .in_user(1'b0),
    .out_data(l_data), .out_valid(l_valid), .out_ready(fire),
    .out_last(l_last), .out_user()
  );

  axis_skid_buffer #(.WIDTH(mm_stream_pkg::ud_w), .USER_W(mm_stream_pkg::user_w)) up_buf (
    .clk(clk), .reset(reset),
    .in_data(up_data), .in_valid(up_valid), .in_ready(up_ready),
    .in_last(up_last), .in_user(up_user),
    .out_data(u_data), .out_valid(u_valid), .out_ready(u_ready),
    .out_last(u_last), .out_user(u_user)
  );

  pe_control #(.ROWS(ROWS), .ROW(ROW), .COL(COL), .COLS(COLS)) ctrl (
    .clk(clk), .reset(reset),
    .left_valid(l_valid), .left_last(l_last),
    .up_valid(u_valid), .up_last(u_last), .up_is_result(u_user.is_result),
    .right_ready(r_ready), .down_ready(d_ready),
    .fire(fire), .acc_clear(acc_clear), .take_up_result(take_up_result),
    .export_own(export_own), .own_last(own_last),
    .err_unaligned(err_unaligned), .err_unexpected(err_unexpected)
  );

  // Up word leaves on a pair, a passed result or a dropped one
  assign u_ready = fire || take_up_result || err_unexpected;

  // Signed MAC
  assign product     = $signed(l_data) * $signed(u_data.w.weight);
  assign acc_base    = acc_clear ? '0 : acc;
  assign acc_shifted = acc >>> result_shift;

  always_ff @(posedge clk) begin
    if (fire) begin
      acc <= acc_base + {{(acc_w - 2*data_w){product[2*data_w-1]}}, product};
    end
  end

  // Down mux: own result, passing result or forwarded weight
  always_comb begin
    own_word.r.row     = row_id;
    // Low bits kept, wraps on overflow
    own_word.r.value   = acc_shifted[data_w-1:0];
    own_user           = '0;
    own_user.is_result = 1'b1;
    d_data  = export_own ? own_word : u_data;
    d_user  = export_own ? own_user : u_user;
    d_last  = export_own ? own_last : u_last;
    d_valid = export_own || take_up_result || (fire && fwd_down);
  end

  axis_skid_buffer #(.WIDTH(data_w), .USER_W(1)) right_buf (
    .clk(clk), .reset(reset),
    .in_data(l_data), .in_valid(fire && fwd_right), .in_ready(r_ready),
    .in_last(l_last), .in_user(1'b0),
    .out_data(right_data), .out_valid(right_valid), .out_ready(right_ready),
    .out_last(right_last), .out_user()
  );

  axis_skid_buffer #(.WIDTH(mm_stream_pkg::ud_w), .USER_W(mm_stream_pkg::user_w)) down_buf (
    .clk(clk), .reset(reset),
    .in_data(d_data), .in_valid(d_valid), .in_ready(d_ready),
    .in_last(d_last), .in_user(d_user),
    .out_data(down_data), .out_valid(down_valid), .out_ready(down_ready),
    .out_last(down_last), .out_user(down_user)
  );

endmodule

// ==== hw/pe_control.sv ====
module pe_control #(
  parameter int ROWS = 2,
  parameter int ROW  = 0,
  parameter int COL  = 0,
  parameter int COLS = 2
) (
  input  logic clk,
  input  logic reset,
  input  logic left_valid,
  input  logic left_last,
  input  logic up_valid,
  input  logic up_last,
  input  logic up_is_result,
  input  logic right_ready,
  input  logic down_ready,
  output logic fire,
  output logic acc_clear,
  output logic take_up_result,
  output logic export_own,
  output logic own_last,
  output logic err_unaligned,
  output logic err_unexpected
);

  // Pass count holds at most ROWS-1
  localparam int cnt_w = (ROWS > 1) ? $clog2(ROWS) : 1;
  // Edge PEs drop what would leave the grid
  localparam bit is_right  = (COL == COLS - 1);
  localparam bit is_bottom = (ROW == ROWS - 1);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_accum = 2'd1;
  localparam logic [1:0] st_drain = 2'd2;

  logic [1:0]       state;
  logic [cnt_w-1:0] pass_cnt;
  logic             in_drain;
  logic             pair_valid;
  logic             targets_ready;
  logic             job_end;
  logic             passing;

  assign in_drain = (state == st_drain);

  // Pair fires when both words are operands and every target can take them
  assign pair_valid    = left_valid && up_valid && !up_is_result && !in_drain;
  assign targets_ready = (is_right || right_ready) && (is_bottom || down_ready);
  assign fire          = pair_valid && targets_ready;
  // First pair after an export restarts the sum
  assign acc_clear     = fire && (state == st_idle);
  // Either tlast ends the job
  assign job_end       = fire && (left_last || up_last);
  assign err_unaligned = fire && (left_last != up_last);

  // Results from above still owed to this column
  assign passing        = in_drain && (pass_cnt != '0);
  assign take_up_result = passing && up_valid && up_is_result && down_ready;
  // Stray result, dropped on the same cycle
  assign err_unexpected = up_valid && up_is_result && !passing;

  // Own result after the rows above have passed
  assign export_own = in_drain && (pass_cnt == '0);
  assign own_last   = export_own && is_bottom;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      pass_cnt <= '0;
    end else begin
      case (state)
        st_idle, st_accum: begin
          if (job_end) begin
            state    <= st_drain;
            pass_cnt <= ROW[cnt_w-1:0];
          end else if (fire) begin
            state <= st_accum;
          end
        end
        st_drain: begin
          if (take_up_result) begin
            pass_cnt <= pass_cnt - 1'b1;
          end
          // Leave once the own result is taken
          if (export_own && down_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== hw/axis_skid_buffer.sv ====
module axis_skid_buffer #(
  parameter int WIDTH  = 16,
  parameter int USER_W = 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [WIDTH-1:0]  in_data,
  input  logic              in_valid,
  output logic              in_ready,
  input  logic              in_last,
  input  logic [USER_W-1:0] in_user,
  output logic [WIDTH-1:0]  out_data,
  output logic              out_valid,
  input  logic              out_ready,
  output logic              out_last,
  output logic [USER_W-1:0] out_user
);

  // Stored word is last, user, data
  localparam int word_w = WIDTH + USER_W + 1;

  logic [word_w-1:0] in_word;
  logic [word_w-1:0] main_word;
  logic [word_w-1:0] skid_word;
  logic              skid_valid;
  logic              skid_next;
  logic              in_fire;
  logic              main_free;

  assign in_word   = {in_last, in_user, in_data};
  assign in_fire   = in_valid && in_ready;
  // Main entry empty or draining this cycle
  assign main_free = out_ready || !out_valid;

  // Skid catches the word accepted while the output stalls
  assign skid_next = main_free ? 1'b0 : (skid_valid || in_fire);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_free) begin
        out_valid <= skid_valid || in_fire;
      end
      skid_valid <= skid_next;
      // Ready only depends on a register
      in_ready   <= !skid_next;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (main_free) begin
      main_word <= skid_valid ? skid_word : in_word;
    end
    if (!skid_valid) begin
      skid_word <= in_word;
    end
  end

  assign {out_last, out_user, out_data} = main_word;

endmodule

// ==== hw/mm_regs_pkg.sv ====
package mm_regs_pkg;

  // Register address and data widths
  localparam int addr_w = 2;
  localparam int reg_data_w = 8;

  // Fractional shift field
  localparam int shift_w = 5;
  localparam logic [shift_w-1:0] shift_reset = 5'd8;

  // Register map
  localparam logic [addr_w-1:0] reg_shift = 2'd0;
  // Read only, sticky
  localparam logic [addr_w-1:0] reg_status = 2'd1;
  // Write only, any data clears the flags
  localparam logic [addr_w-1:0] reg_clear = 2'd2;

  // Status bit positions
  localparam int status_unaligned = 0;
  localparam int status_unexpected = 1;
  localparam int status_w = 2;

endpackage

// ==== hw/mm_stream_pkg.sv ====
package mm_stream_pkg;

  // Operand and result word
  localparam int data_w = 16;
  // Accumulator, room for long dot products
  localparam int acc_w = 40;
  // Source row index carried with each result
  localparam int row_idx_w = 2;
  // Up/down tdata width
  localparam int ud_w = row_idx_w + data_w;
  // Up/down tuser width
  localparam int user_w = 2;

  // Weight view, top bits unused
  typedef struct packed {
    logic [row_idx_w-1:0]     reserved;
    logic signed [data_w-1:0] weight;
  } weight_view_t;

  // Result view, tagged with the producing row
  typedef struct packed {
    logic [row_idx_w-1:0]     row;
    logic signed [data_w-1:0] value;
  } result_view_t;

  // One up/down word, decoded by tuser.is_result
  typedef union packed {
    weight_view_t w;
    result_view_t r;
  } ud_word_u;

  typedef struct packed {
    logic spare;
    logic is_result;
  } user_t;

endpackage
